/* source/cacc_width_pkg.sv */
/* widths and vector types of the int16 accumulate arithmetic
   import into any block that touches product sums, partial sums or final values */
package cacc_width_pkg;

  // ==================================================
  // raw widths
  // ==================================================
  // product sum from the mac array
  localparam int PROD_W  = 38;
  // stored partial sum
  localparam int ACC_W   = 48;
  // final result after truncation
  localparam int OUT_W   = 32;
  // low half of the split adder
  localparam int LSB_W   = 32;
  // truncate setting, shift of 0 to 31
  localparam int TRUNC_W = 5;

  // ==================================================
  // vector types
  // ==================================================
  typedef logic [PROD_W-1:0]      prod_t;
  typedef logic [ACC_W-1:0]       acc_t;
  typedef logic [OUT_W-1:0]       out_t;
  typedef logic [TRUNC_W-1:0]     trunc_t;
  // low sum keeps its carry in the top bit
  typedef logic [LSB_W:0]         lsum_t;
  // high sum, one guard bit above the 48-bit range
  typedef logic [ACC_W-LSB_W:0]   hsum_t;

endpackage

/* source/cacc_stage_pkg.sv */
/* pipeline contents passed between the accumulate stages
   one struct per hop, shared by producer and consumer */
package cacc_stage_pkg;

  import cacc_width_pkg::*;

  // one input beat as sampled at the top ports
  typedef struct packed {
    prod_t data;
    acc_t  op;
    logic  op_valid;
    logic  sel;
    logic  valid;
  } calc_in_s;

  // registered split sum, sum stage to out stage
  typedef struct packed {
    lsum_t lsum;
    hsum_t hsum;
    logic  data_sign;
    logic  op_sign;
    // both upper parts were pure sign extension, hsum not valid
    logic  hsb_same;
    logic  sel;
    logic  valid;
  } sum_stage_s;

  // narrowed final value and its clamp flag
  typedef struct packed {
    out_t data;
    logic sat;
  } final_s;

endpackage

/* source/cacc_sum_stage.sv */
/* first accumulate stage: operand masking, split 32/16 adder and the pipeline register
   output is the registered split sum consumed by the output stage */
`timescale 1ns/10ps
module cacc_sum_stage
  import cacc_width_pkg::*;
  import cacc_stage_pkg::*;
(
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  calc_in_s   i_beat,
  output sum_stage_s o_stage
);

  // upper part widths above the low adder
  localparam int DHSB_W = PROD_W - LSB_W;
  localparam int OHSB_W = ACC_W - LSB_W;

  acc_t              op_mask;
  logic [LSB_W-1:0]  data_lsb;
  logic [LSB_W-1:0]  op_lsb;
  logic [DHSB_W-1:0] data_hsb;
  logic [OHSB_W-1:0] op_hsb;
  logic              data_sign;
  logic              op_sign;
  logic              hsb_same;
  lsum_t             lsum_nxt;
  hsum_t             hsum_nxt;

  lsum_t             lsum_q;
  hsum_t             hsum_q;
  logic              data_sign_q;
  logic              op_sign_q;
  logic              hsb_same_q;
  logic              sel_q;
  logic              valid_q;

  // ==================================================
  // operand split
  // ==================================================
  // partial sum counts as zero without op_valid
  assign op_mask   = i_beat.op_valid ? i_beat.op : '0;

  assign data_sign = i_beat.data[PROD_W-1];
  assign op_sign   = op_mask[ACC_W-1];
  assign data_lsb  = i_beat.data[LSB_W-1:0];
  assign op_lsb    = op_mask[LSB_W-1:0];
  assign data_hsb  = i_beat.data[PROD_W-1:LSB_W];
  assign op_hsb    = op_mask[ACC_W-1:LSB_W];

  // upper bits all zeros or all ones on both sides
  assign hsb_same = ((data_hsb == '0) || (data_hsb == '1)) &&
                    ((op_hsb == '0) || (op_hsb == '1));

  // ==================================================
  // split addition
  // ==================================================
  // unsigned low add, carry lands in bit 32
  assign lsum_nxt = {1'b0, data_lsb} + {1'b0, op_lsb};

  // signed upper add plus low carry
  assign hsum_nxt = {{(OHSB_W-DHSB_W+1){data_hsb[DHSB_W-1]}}, data_hsb} +
                    {op_hsb[OHSB_W-1], op_hsb} +
                    {{OHSB_W{1'b0}}, lsum_nxt[LSB_W]};

  // ==================================================
  // pipeline register
  // ==================================================
  // control side
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      valid_q     <= 1'b0;
      sel_q       <= 1'b0;
      data_sign_q <= 1'b0;
      op_sign_q   <= 1'b0;
      hsb_same_q  <= 1'b0;
    end else begin
      valid_q <= i_beat.valid;
      if (i_beat.valid) begin
        sel_q       <= i_beat.sel;
        data_sign_q <= data_sign;
        op_sign_q   <= op_sign;
        hsb_same_q  <= hsb_same;
      end
    end
  end

  // sums, loaded per beat only
  always_ff @(posedge nvdla_core_clk) begin
    if (i_beat.valid) begin
      lsum_q <= lsum_nxt;
    end
    // high half only written when it carries information
    if (i_beat.valid && !hsb_same) begin
      hsum_q <= hsum_nxt;
    end
  end

  assign o_stage = '{lsum:      lsum_q,
                     hsum:      hsum_q,
                     data_sign: data_sign_q,
                     op_sign:   op_sign_q,
                     hsb_same:  hsb_same_q,
                     sel:       sel_q,
                     valid:     valid_q};

endmodule

/* source/cacc_narrow.sv */
/* narrows a 48-bit accumulated value to a 32-bit final result
   arithmetic shift by the truncate setting, round half away from zero, clamp */
`timescale 1ns/10ps
module cacc_narrow
  import cacc_width_pkg::*;
  import cacc_stage_pkg::*;
(
  input  acc_t   i_value,
  input  trunc_t i_truncate,
  output final_s o_result
);

  // fraction window below the shifted value, guide plus sticky
  localparam int FRAC_W = 16;

  logic [ACC_W-1:0]  sft;
  logic              guide;
  logic [FRAC_W-2:0] stick;
  logic              sign;
  logic              point5;
  logic              need_sat;
  out_t              rounded;
  out_t              sat_max;

  assign sign = i_value[ACC_W-1];

  // ==================================================
  // shift
  // ==================================================
  // append the fraction window, then shift as signed
  // bits falling below the window are dropped
  assign {sft, guide, stick} = $signed({i_value, {FRAC_W{1'b0}}}) >>> i_truncate;

  // ==================================================
  // rounding
  // ==================================================
  // exact tie on a negative value stays at the floor
  assign point5 = guide & (~sign | (|stick));

  // carry out of bit 31 is covered by need_sat below
  assign rounded = sft[OUT_W-1:0] + out_t'(point5);

  // ==================================================
  // 32-bit saturation
  // ==================================================
  // negative: upper bits not all ones
  // positive: any upper bit set, or rounding wraps 0x7fffffff
  assign need_sat = (sign  & ~(&sft[ACC_W-2:OUT_W-1])) |
                    (~sign &  (|sft[ACC_W-2:OUT_W-1])) |
                    (~sign &  (&{sft[OUT_W-2:0], point5}));

  assign sat_max = sign ? {1'b1, {(OUT_W-1){1'b0}}} : {1'b0, {(OUT_W-1){1'b1}}};

  assign o_result = '{data: need_sat ? sat_max : rounded,
                      sat:  need_sat};

endmodule

/* source/cacc_out_stage.sv */
/* second accumulate stage: rebuilds the 48-bit saturated sum and steers it
   to the partial or final output register, final values via the narrowing block */
`timescale 1ns/10ps
module cacc_out_stage
  import cacc_width_pkg::*;
  import cacc_stage_pkg::*;
(
  input  logic       nvdla_core_clk,
  input  logic       nvdla_core_rstn,
  input  sum_stage_s i_stage,
  input  trunc_t     i_truncate,
  output acc_t       o_partial_data,
  output logic       o_partial_valid,
  output out_t       o_final_data,
  output logic       o_final_sat,
  output logic       o_final_valid
);

  // bits above the low adder
  localparam int HI_W = ACC_W - LSB_W;

  logic [HI_W-1:0] hsame_ext;
  acc_t            last_val;
  acc_t            hsum_val;
  acc_t            sat_val;
  logic            hsum_sign;
  logic            hsum_msb;
  final_s          narrow_res;
  logic            partial_vld;
  logic            final_vld;

  // ==================================================
  // rebuild from signs, upper parts were sign extension
  // ==================================================
  always_comb begin
    if (i_stage.data_sign ^ i_stage.op_sign) begin
      // mixed signs, a carry means the result went non-negative
      hsame_ext = {HI_W{~i_stage.lsum[LSB_W]}};
    end else begin
      // same signs, carry becomes bit 32
      hsame_ext = {{(HI_W-1){i_stage.op_sign}}, i_stage.lsum[LSB_W]};
    end
  end

  assign last_val = {hsame_ext, i_stage.lsum[LSB_W-1:0]};

  // ==================================================
  // rebuild from high sum, clamp to 48 bits
  // ==================================================
  assign hsum_sign = i_stage.hsum[HI_W];
  assign hsum_msb  = i_stage.hsum[HI_W-1];

  always_comb begin
    if (hsum_sign ^ hsum_msb) begin
      // guard bit disagrees, clamp toward the sign
      hsum_val = {hsum_sign, {(ACC_W-1){~hsum_sign}}};
    end else begin
      hsum_val = {hsum_sign, i_stage.hsum[HI_W-2:0], i_stage.lsum[LSB_W-1:0]};
    end
  end

  assign sat_val = i_stage.hsb_same ? last_val : hsum_val;

  // final path narrowing
  cacc_narrow u_narrow (
    .i_value    (sat_val),
    .i_truncate (i_truncate),
    .o_result   (narrow_res)
  );

  // ==================================================
  // output registers
  // ==================================================
  assign partial_vld = i_stage.valid & ~i_stage.sel;
  assign final_vld   = i_stage.valid & i_stage.sel;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      o_partial_valid <= 1'b0;
      o_final_valid   <= 1'b0;
      o_final_sat     <= 1'b0;
    end else begin
      o_partial_valid <= partial_vld;
      o_final_valid   <= final_vld;
      // flag only meaningful with its strobe
      o_final_sat     <= final_vld & narrow_res.sat;
    end
  end

  // data holds between beats
  always_ff @(posedge nvdla_core_clk) begin
    if (partial_vld) begin
      o_partial_data <= sat_val;
    end
    if (final_vld) begin
      o_final_data <= narrow_res.data;
    end
  end

endmodule

/* source/cacc_calc_int16.sv */
/* int16 accumulate step of the convolution accumulator, two cycles from beat to result
   sum stage feeds the output stage, no back-pressure */
`timescale 1ns/10ps
module cacc_calc_int16
  import cacc_width_pkg::*;
  import cacc_stage_pkg::*;
(
  input  logic   nvdla_core_clk,
  input  logic   nvdla_core_rstn,
  // static config
  input  trunc_t i_cfg_truncate,
  // input beat
  input  prod_t  i_data,
  input  acc_t   i_op,
  input  logic   i_op_valid,
  input  logic   i_sel,
  input  logic   i_valid,
  // partial result
  output acc_t   o_partial_data,
  output logic   o_partial_valid,
  // final result
  output out_t   o_final_data,
  output logic   o_final_sat,
  output logic   o_final_valid
);

  calc_in_s   beat;
  sum_stage_s stage;

  // ==================================================
  // port packing
  // ==================================================
  assign beat = '{data:     i_data,
                  op:       i_op,
                  op_valid: i_op_valid,
                  sel:      i_sel,
                  valid:    i_valid};

  // ==================================================
  // stages
  // ==================================================
  // add and register, one cycle
  cacc_sum_stage u_sum_stage (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .i_beat          (beat),
    .o_stage         (stage)
  );

  // saturate, narrow and register, one cycle
  cacc_out_stage u_out_stage (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .i_stage         (stage),
    .i_truncate      (i_cfg_truncate),
    .o_partial_data  (o_partial_data),
    .o_partial_valid (o_partial_valid),
    .o_final_data    (o_final_data),
    .o_final_sat     (o_final_sat),
    .o_final_valid   (o_final_valid)
  );

endmodule

/* sim/tb_clk_gen.sv */
/* clock and reset source for the accumulate testbench
   10 ns clock, active-low reset held for the first 5 cycles */
`timescale 1ns/10ps
module tb_clk_gen (
  output logic o_clk,
  output logic o_rstn
);

  localparam real HALF_PERIOD = 5.0;
  localparam int  RST_CYCLES  = 5;

  // free-running core clock
  initial begin
    o_clk = 1'b0;
    forever begin
      #(HALF_PERIOD) o_clk = ~o_clk;
    end
  end

  // reset held low, released on a falling edge
  initial begin
    o_rstn = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rstn = 1'b1;
  end

endmodule

/* sim/tb_cacc_calc.sv */
/* testbench for the int16 accumulate step, random and directed beats
   expected results queued from a reference model and compared on each output strobe */
`timescale 1ns/10ps
module tb_cacc_calc
  import cacc_width_pkg::*;
();

  localparam int     DRAIN_LIMIT = 50;
  localparam int     RESET_LIMIT = 100;
  localparam longint MAX48 = (64'sd1 <<< 47) - 64'sd1;
  localparam longint MIN48 = -(64'sd1 <<< 47);
  localparam longint MAX38 = (64'sd1 <<< 37) - 64'sd1;
  localparam longint MIN38 = -(64'sd1 <<< 37);
  localparam longint MAX32 = (64'sd1 <<< 31) - 64'sd1;
  localparam longint MIN32 = -(64'sd1 <<< 31);

  // one expected output beat
  typedef struct packed {
    logic        sel;
    acc_t        partial;
    out_t        fin;
    logic        sat;
    logic [31:0] cycle;
  } expect_s;

  logic        clk;
  logic        rstn;
  trunc_t      cfg_truncate;
  prod_t       data;
  acc_t        op;
  logic        op_valid;
  logic        sel;
  logic        valid;
  acc_t        partial_data;
  logic        partial_valid;
  out_t        final_data;
  logic        final_sat;
  logic        final_valid;

  expect_s     exp_q[$];
  logic [63:0] rng_state;
  logic [31:0] cyc = '0;
  string       cur_test;

  tb_clk_gen u_clk_gen (
    .o_clk  (clk),
    .o_rstn (rstn)
  );

  cacc_calc_int16 UUT (
    .nvdla_core_clk  (clk),
    .nvdla_core_rstn (rstn),
    .i_cfg_truncate  (cfg_truncate),
    .i_data          (data),
    .i_op            (op),
    .i_op_valid      (op_valid),
    .i_sel           (sel),
    .i_valid         (valid),
    .o_partial_data  (partial_data),
    .o_partial_valid (partial_valid),
    .o_final_data    (final_data),
    .o_final_sat     (final_sat),
    .o_final_valid   (final_valid)
  );

  // cycle count, used to time each result
  always @(posedge clk) begin
    cyc <= cyc + 32'd1;
  end

  // ==================================================
  // helpers and reference model
  // ==================================================
  function automatic logic [63:0] xorshift64();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  // sign extend the low w bits
  function automatic longint sext(logic [63:0] v, int w);
    longint s;
    s = longint'(v);
    s = (s <<< (64 - w)) >>> (64 - w);
    return s;
  endfunction

  // small, mid, full-range or near-limit value of width w
  function automatic longint rand_val(int w);
    logic [63:0] r;
    longint      lim;
    r   = xorshift64();
    lim = 64'sd1 <<< (w - 1);
    case (r[63:62])
      2'd0:    return sext(r, 16);
      2'd1:    return sext(r, 34);
      2'd2:    return sext(r, w);
      default: return r[8] ? (lim - 64'sd1 - longint'(r[7:0])) : (longint'(r[7:0]) - lim);
    endcase
  endfunction

  // exact sum, 48-bit clamp, then shift, round and 32-bit clamp
  function automatic expect_s reference(prod_t d_in, acc_t op_in, logic opv,
                                        logic sel_in, trunc_t t_in);
    expect_s e;
    longint  d;
    longint  o;
    longint  s;
    longint  fl;
    longint  frac;
    longint  rnd;
    int      t;
    int      lo;
    int      cnt;
    logic    guide;
    logic    sticky;
    d = longint'($signed(d_in));
    o = 64'sd0;
    if (opv) begin
      o = longint'($signed(op_in));
    end
    s = d + o;
    if (s > MAX48) s = MAX48;
    if (s < MIN48) s = MIN48;
    t      = int'(t_in);
    fl     = s >>> t;
    frac   = s - (fl <<< t);
    guide  = 1'b0;
    sticky = 1'b0;
    if (t > 0) begin
      // guide bit, then up to 15 sticky bits under it
      guide  = frac[t-1];
      lo     = (t > 16) ? (t - 16) : 0;
      cnt    = (t - 1 < 15) ? (t - 1) : 15;
      sticky = ((frac >>> lo) & ((64'sd1 <<< cnt) - 64'sd1)) != 64'sd0;
    end
    rnd = fl;
    if (guide && ((s >= 0) || sticky)) begin
      rnd = fl + 64'sd1;
    end
    e.sel     = sel_in;
    e.partial = s[47:0];
    e.sat     = (rnd > MAX32) || (rnd < MIN32);
    if (rnd > MAX32) rnd = MAX32;
    if (rnd < MIN32) rnd = MIN32;
    e.fin   = rnd[31:0];
    e.cycle = '0;
    return e;
  endfunction

  // ==================================================
  // checks
  // ==================================================
  task automatic check_equal(string field, logic [63:0] exp_v, logic [63:0] act_v);
    if (exp_v !== act_v) begin
      $display("ERR %s %s expected 0x%0h actual 0x%0h", cur_test, field, exp_v, act_v);
      $display("Done: errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic stop_with_error(string why);
    $display("%s: %s", cur_test, why);
    $display("Done: errors found");
    $fatal(1, "run stopped");
  endtask

  // compare each strobe with the oldest expected beat
  always @(negedge clk) begin : compare_outputs
    expect_s e;
    if (rstn && (partial_valid || final_valid)) begin
      if (exp_q.size() == 0) begin
        stop_with_error("output strobe with no beat pending");
      end else begin
        e = exp_q.pop_front();
        check_equal("one_strobe", 64'd1, 64'(partial_valid ^ final_valid));
        check_equal("kind", 64'(e.sel), 64'(final_valid));
        check_equal("cycle", 64'(e.cycle), 64'(cyc));
        if (e.sel) begin
          check_equal("final_data", 64'(e.fin), 64'(final_data));
          check_equal("final_sat", 64'(e.sat), 64'(final_sat));
        end else begin
          check_equal("partial_data", 64'(e.partial), 64'(partial_data));
          check_equal("final_sat", 64'd0, 64'(final_sat));
        end
      end
    end
  end

  // ==================================================
  // stimulus tasks
  // ==================================================
  // one beat, result due two cycles later
  task automatic send_beat(longint d, longint o, logic opv, logic s);
    expect_s e;
    @(posedge clk);
    #1;
    data     = prod_t'(d);
    op       = acc_t'(o);
    op_valid = opv;
    sel      = s;
    valid    = 1'b1;
    e        = reference(data, op, opv, s, cfg_truncate);
    e.cycle  = cyc + 32'd2;
    exp_q.push_back(e);
  endtask

  task automatic go_idle();
    @(posedge clk);
    #1;
    valid    = 1'b0;
    op_valid = 1'b0;
    sel      = 1'b0;
  endtask

  // truncate only changes with nothing in flight
  task automatic set_truncate(int t);
    @(posedge clk);
    #1;
    cfg_truncate = trunc_t'(t);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0) && (n < DRAIN_LIMIT)) begin
      @(posedge clk);
      n = n + 1;
    end
    if (exp_q.size() != 0) begin
      stop_with_error("expected results still pending after timeout");
    end
  endtask

  task automatic wait_reset();
    int n;
    n = 0;
    while (!rstn && (n < RESET_LIMIT)) begin
      @(posedge clk);
      n = n + 1;
    end
    if (!rstn) begin
      stop_with_error("reset never released");
    end
  endtask

  // ==================================================
  // test sequence
  // ==================================================
  initial begin
    logic [63:0] r;
    int          tlist[5];
    int          t;
    rng_state    = 64'd94;
    tlist        = '{0, 1, 7, 15, 31};
    cfg_truncate = '0;
    data         = '0;
    op           = '0;
    op_valid     = 1'b0;
    sel          = 1'b0;
    valid        = 1'b0;
    cur_test     = "reset";
    wait_reset();

    // quiet outputs with no input
    repeat (20) begin
      @(negedge clk);
      check_equal("partial_valid", 64'd0, 64'(partial_valid));
      check_equal("final_valid", 64'd0, 64'(final_valid));
      check_equal("final_sat", 64'd0, 64'(final_sat));
    end

    cur_test = "partial_random";
    repeat (300) begin
      r = xorshift64();
      send_beat(rand_val(PROD_W), rand_val(ACC_W), r[0], 1'b0);
    end
    go_idle();
    wait_drain();

    // operands at and near the 48-bit limits
    cur_test = "sat48";
    send_beat(MAX38, MAX48, 1'b1, 1'b0);
    send_beat(MIN38, MIN48, 1'b1, 1'b0);
    send_beat(64'sd10, MAX48 - 64'sd4, 1'b1, 1'b0);
    send_beat(-64'sd7, MIN48 + 64'sd3, 1'b1, 1'b0);
    send_beat(MAX38, MAX48 - MAX38, 1'b1, 1'b0);
    send_beat(MIN38, MAX48, 1'b0, 1'b0);
    send_beat(64'sd1, MAX48, 1'b1, 1'b1);
    go_idle();
    wait_drain();

    // every shift, random values plus exact ties of both signs
    cur_test = "final_random";
    for (t = 0; t < 32; t = t + 1) begin
      set_truncate(t);
      repeat (24) begin
        r = xorshift64();
        send_beat(rand_val(PROD_W), rand_val(ACC_W), r[0], 1'b1);
      end
      if (t > 0) begin
        send_beat(64'sd0, (64'sd3 <<< t) + (64'sd1 <<< (t - 1)), 1'b1, 1'b1);
        send_beat(64'sd0, -(64'sd3 <<< t) - (64'sd1 <<< (t - 1)), 1'b1, 1'b1);
        send_beat(-(64'sd5 <<< t) - (64'sd1 <<< (t - 1)), 64'sd0, 1'b0, 1'b1);
        send_beat((64'sd5 <<< t) + (64'sd1 <<< (t - 1)), 64'sd0, 1'b0, 1'b1);
      end
      go_idle();
      wait_drain();
    end

    // clamps and rounding carries at the 32-bit edge
    cur_test = "sat32";
    foreach (tlist[k]) begin
      t = tlist[k];
      set_truncate(t);
      send_beat(64'sd0, MAX48, 1'b1, 1'b1);
      send_beat(64'sd0, MIN48, 1'b1, 1'b1);
      if (t <= 15) begin
        send_beat(64'sd0, MAX32 <<< t, 1'b1, 1'b1);
        send_beat(64'sd0, 64'sd1 <<< (31 + t), 1'b1, 1'b1);
        send_beat(64'sd0, MIN32 <<< t, 1'b1, 1'b1);
        send_beat(64'sd0, 64'sd1000 <<< t, 1'b1, 1'b1);
        if (t > 0) begin
          send_beat(64'sd0, (MAX32 <<< t) + (64'sd1 <<< (t - 1)), 1'b1, 1'b1);
        end
      end
      go_idle();
      wait_drain();
    end

    // partial and final beats on consecutive cycles
    cur_test = "mixed_b2b";
    set_truncate(9);
    repeat (300) begin
      r = xorshift64();
      send_beat(rand_val(PROD_W), rand_val(ACC_W), r[0], r[1]);
    end
    go_idle();
    wait_drain();

    if (exp_q.size() == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("%0d expected results never came out", exp_q.size());
      $display("Done: errors found");
      $fatal(1, "run stopped");
    end
  end

endmodule

/* build.f */
source/cacc_width_pkg.sv
source/cacc_stage_pkg.sv
source/cacc_sum_stage.sv
source/cacc_narrow.sv
source/cacc_out_stage.sv
source/cacc_calc_int16.sv
sim/tb_clk_gen.sv
sim/tb_cacc_calc.sv
